//--- include/osc_cfg.svh
`ifndef OSC_CFG_SVH
`define OSC_CFG_SVH

// Phase accumulator and tuning word width
// One full turn is 2**OSC_PHASE_W
`define OSC_PHASE_W 16

// Core reset hold time after rst is released, in xtal_in cycles
`define OSC_STARTUP_CYCLES 8

// Frequency meter gate window, in xtal_in cycles
// Keep a power of two so the gate counter wraps cleanly
`define OSC_GATE_CYCLES 256

// Entries in the tuning word table
`define OSC_PROFILE_COUNT 4

`endif

//--- design/osc_clk_pkg.sv
`include "osc_cfg.svh"

package osc_clk_pkg;

    // Startup counter must be able to hold OSC_STARTUP_CYCLES itself
    localparam int STARTUP_CNT_W = $clog2(`OSC_STARTUP_CYCLES + 1);

    // Gate counter spans one window and wraps at its end
    localparam int GATE_CNT_W = $clog2(`OSC_GATE_CYCLES);

    // Counts cycles of core reset after rst falls
    typedef logic [STARTUP_CNT_W-1:0] startup_cnt_t;

    // Position inside the meter gate window
    typedef logic [GATE_CNT_W-1:0] gate_cnt_t;

endpackage

//--- design/nco_pkg.sv
`include "osc_cfg.svh"

package nco_pkg;

    // Phase word, also used for the phase offset
    typedef logic [`OSC_PHASE_W-1:0] phase_t;

    // Frequency tuning word, added to the phase every cycle
    typedef logic [`OSC_PHASE_W-1:0] tuning_t;

    // Index into the profile table
    typedef logic [1:0] profile_sel_t;

    // Rising edges seen in one gate window
    // At most half the window, plus headroom
    typedef logic [8:0] edge_cnt_t;

    // Tuning words per profile
    // Output frequency is f_xtal * word / 2**16
    localparam tuning_t profile_table [`OSC_PROFILE_COUNT] = '{
        16'h3300,
        16'h1000,
        16'h0800,
        16'h4000
    };

    // Quadrature path leads by 90 degrees
    localparam phase_t quarter_turn = 16'h4000;

endpackage

//--- design/tuning_if.sv
// Tuning control from the profile selector to the NCO and the meter
interface tuning_if;
    import nco_pkg::*;

    // Active tuning word and phase offset
    tuning_t tuning_word;
    phase_t  phase_offset;

    // One cycle pulse, restarts phase and gate window
    logic load;

    // High from the first load onward
    logic enable;

    modport src
    (
        output tuning_word,
        output phase_offset,
        output load,
        output enable
    );

    modport dst
    (
        input tuning_word,
        input phase_offset,
        input load,
        input enable
    );

endinterface

//--- design/startup_reset.sv
`include "osc_cfg.svh"

module startup_reset
(
    input  logic xtal_in,
    input  logic rst,
    output logic core_rst
);
    import osc_clk_pkg::*;

    // Cycles counted since rst fell
    startup_cnt_t startup_cnt;

    always_ff @(posedge xtal_in)
    begin
        if (rst)
        begin
            // External reset holds everything
            startup_cnt <= '0;
            core_rst    <= 1'b1;
        end
        else if (core_rst)
        begin
            // Release once the hold time has elapsed
            if (startup_cnt == startup_cnt_t'(`OSC_STARTUP_CYCLES))
            begin
                core_rst <= 1'b0;
            end
            else
            begin
                startup_cnt <= startup_cnt + startup_cnt_t'(1);
            end
        end
        // Counter parks at its final value while core_rst is low
    end

endmodule

//--- design/tuning_select.sv
module tuning_select
(
    input  logic                  xtal_in,
    input  logic                  core_rst,
    input  nco_pkg::profile_sel_t profile_sel,
    input  nco_pkg::phase_t       phase_offset,
    input  logic                  apply,
    tuning_if.src                 tun
);
    import nco_pkg::*;

    // Table lookup for the requested profile
    tuning_t lookup_word;

    // Apply only counts once core reset is released
    logic apply_ok;

    assign lookup_word = profile_table[profile_sel];
    assign apply_ok    = apply & ~core_rst;

    // Control strobes
    always_ff @(posedge xtal_in)
    begin
        if (core_rst)
        begin
            tun.load   <= 1'b0;
            tun.enable <= 1'b0;
        end
        else
        begin
            // Single cycle pulse per apply
            tun.load <= apply;
            // Sticky once a profile has been loaded
            if (apply)
            begin
                tun.enable <= 1'b1;
            end
        end
    end

    // Tuning payload
    // Valid in the same cycle that load goes high
    always_ff @(posedge xtal_in)
    begin
        if (apply_ok)
        begin
            tun.tuning_word  <= lookup_word;
            tun.phase_offset <= phase_offset;
        end
    end

endmodule

//--- design/nco_core.sv
module nco_core
(
    input  logic  xtal_in,
    input  logic  core_rst,
    tuning_if.dst tun,
    output logic  i_code,
    output logic  q_code
);
    import nco_pkg::*;

    // Accumulated phase, without offset
    phase_t phase_acc;

    // Phase used this cycle, zero on load
    phase_t phase_cur;

    // Shifted phases for both outputs
    phase_t i_phase;
    phase_t q_phase;

    always_comb
    begin
        // Load restarts the trajectory from zero
        phase_cur = tun.load ? '0 : phase_acc;
        // Offset applied after accumulation, modulo one turn
        i_phase   = phase_cur + tun.phase_offset;
        // Quadrature leads by a quarter turn
        q_phase   = i_phase + quarter_turn;
    end

    always_ff @(posedge xtal_in)
    begin
        if (core_rst)
        begin
            phase_acc <= '0;
            i_code    <= 1'b0;
            q_code    <= 1'b0;
        end
        else if (tun.enable)
        begin
            // Step by the tuning word every cycle
            phase_acc <= phase_cur + tun.tuning_word;
            // MSB of phase gives a 50% duty square wave
            i_code    <= i_phase[$bits(phase_t)-1];
            q_code    <= q_phase[$bits(phase_t)-1];
        end
        // Outputs stay low until the first profile arrives
    end

endmodule

//--- design/freq_meter.sv
`include "osc_cfg.svh"

module freq_meter
(
    input  logic               xtal_in,
    input  logic               core_rst,
    tuning_if.dst              tun,
    input  logic               i_code,
    output nco_pkg::edge_cnt_t edge_count,
    output logic               count_valid
);
    import osc_clk_pkg::*;
    import nco_pkg::*;

    // Last cycle of a gate window
    localparam gate_cnt_t GATE_LAST = gate_cnt_t'(`OSC_GATE_CYCLES - 1);

    // Previous i_code for edge detection
    logic i_code_d;
    logic rise;

    // Position in the current window
    gate_cnt_t gate_cnt;

    // Running total for the current window
    edge_cnt_t edge_acc;

    // Rising edge of the synthesized clock
    assign rise = i_code & ~i_code_d;

    always_ff @(posedge xtal_in)
    begin
        if (core_rst)
        begin
            i_code_d    <= 1'b0;
            gate_cnt    <= '0;
            edge_acc    <= '0;
            edge_count  <= '0;
            count_valid <= 1'b0;
        end
        else
        begin
            i_code_d    <= i_code;
            count_valid <= 1'b0;
            if (tun.load)
            begin
                // New profile, restart the window
                gate_cnt <= '0;
                edge_acc <= '0;
            end
            else if (tun.enable)
            begin
                // Wraps to zero at the end of each window
                gate_cnt <= gate_cnt + gate_cnt_t'(1);
                if (gate_cnt == GATE_LAST)
                begin
                    // Publish including the edge on the last cycle
                    edge_count  <= edge_acc + edge_cnt_t'(rise);
                    count_valid <= 1'b1;
                    // Next window starts immediately
                    edge_acc    <= '0;
                end
                else
                begin
                    edge_acc <= edge_acc + edge_cnt_t'(rise);
                end
            end
        end
    end

endmodule

//--- design/osc_top.sv
`include "osc_cfg.svh"

module osc_top
(
    input  logic                    xtal_in,
    input  logic                    rst,
    input  logic [1:0]              profile_sel,
    input  logic [`OSC_PHASE_W-1:0] phase_offset,
    input  logic                    apply,
    output logic                    i_code,
    output logic                    q_code,
    output logic                    core_rst,
    output logic [8:0]              edge_count,
    output logic                    count_valid
);

    // Tuning control shared by selector, NCO and meter
    tuning_if tun ();

    // Startup reset for the whole core, also exported
    startup_reset u_startup_reset
    (
        .xtal_in  (xtal_in),
        .rst      (rst),
        .core_rst (core_rst)
    );

    // Profile lookup and apply strobe
    tuning_select u_tuning_select
    (
        .xtal_in      (xtal_in),
        .core_rst     (core_rst),
        .profile_sel  (profile_sel),
        .phase_offset (phase_offset),
        .apply        (apply),
        .tun          (tun.src)
    );

    // Phase accumulator and I/Q outputs
    nco_core u_nco_core
    (
        .xtal_in  (xtal_in),
        .core_rst (core_rst),
        .tun      (tun.dst),
        .i_code   (i_code),
        .q_code   (q_code)
    );

    // Measures the in-phase output only
    freq_meter u_freq_meter
    (
        .xtal_in     (xtal_in),
        .core_rst    (core_rst),
        .tun         (tun.dst),
        .i_code      (i_code),
        .edge_count  (edge_count),
        .count_valid (count_valid)
    );

endmodule

//--- verification/osc_top_tb.sv
`include "osc_cfg.svh"

module osc_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import nco_pkg::*;

    localparam int STARTUP       = `OSC_STARTUP_CYCLES;
    localparam int GATE          = `OSC_GATE_CYCLES;
    localparam int TRACE_CYCLES  = 300;
    localparam int RESET_TIMEOUT = 64;
    localparam int VALID_TIMEOUT = 3 * GATE;

    // Quadrature lead of one quarter turn
    localparam phase_t QUARTER = 16'h4000;

    localparam logic [31:0] SEED = 32'h02e6_a824;

    // One row per profile
    typedef struct packed
    {
        profile_sel_t sel;
        phase_t       offset;
        tuning_t      word;
        edge_cnt_t    count;
    } stim_row_t;

    // DUT connections
    logic         xtal_in;
    logic         rst;
    profile_sel_t profile_sel;
    phase_t       phase_offset;
    logic         apply;
    logic         i_code;
    logic         q_code;
    logic         core_rst;
    edge_cnt_t    edge_count;
    logic         count_valid;

    stim_row_t   stim_table [`OSC_PROFILE_COUNT];
    logic [31:0] rnd_word;
    phase_t      reapply_off;

    osc_top u_osc_top
    (
        .xtal_in      (xtal_in),
        .rst          (rst),
        .profile_sel  (profile_sel),
        .phase_offset (phase_offset),
        .apply        (apply),
        .i_code       (i_code),
        .q_code       (q_code),
        .core_rst     (core_rst),
        .edge_count   (edge_count),
        .count_valid  (count_valid)
    );

    // 20 ns crystal period
    always #10 xtal_in = ~xtal_in;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_code(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            report_failure($sformatf("mismatch %0t ns: %s got %b expected %b",
                                     $time, what, actual, expected));
        end
    endtask

    // Tolerance absorbs a partial cycle at the window boundary
    task automatic check_count(input edge_cnt_t actual, input edge_cnt_t expected,
                               input int tol, input string what);
        int diff;
        diff = int'(actual) - int'(expected);
        if ((^actual === 1'bx) || (diff > tol) || (diff < -tol))
        begin
            report_failure($sformatf("mismatch %0t ns: %s got %0d expected %0d +/- %0d",
                                     $time, what, actual, expected, tol));
        end
    endtask

    // Outputs sampled and inputs driven 2 ns past the edge
    task automatic next_cycle;
        @(posedge xtal_in);
        #2;
    endtask

    // Top bit of k steps of the tuning word plus offset modulo one turn
    function automatic logic model_code(input tuning_t word, input phase_t off,
                                        input int k, input phase_t shift);
        logic [31:0] step_sum;
        phase_t      phase;
        step_sum = word * k;
        phase    = step_sum[`OSC_PHASE_W-1:0] + off + shift;
        return phase[`OSC_PHASE_W-1];
    endfunction

    task automatic set_row(input int idx, input profile_sel_t sel, input logic random_off,
                           input phase_t off, input tuning_t word, input edge_cnt_t count);
        logic [31:0] rnd;
        rnd = $urandom;
        stim_table[idx].sel    = sel;
        stim_table[idx].offset = random_off ? rnd[`OSC_PHASE_W-1:0] : off;
        stim_table[idx].word   = word;
        stim_table[idx].count  = count;
    endtask

    // Holds apply through every startup edge, expects release after STARTUP+1 edges
    task automatic wait_core_release;
        int edges;
        edges = 0;
        while (core_rst !== 1'b0)
        begin
            if (edges >= RESET_TIMEOUT)
            begin
                report_failure("timeout: core_rst was never released");
            end
            next_cycle;
            edges++;
            check_code(core_rst, edges <= STARTUP, $sformatf("core_rst edge %0d", edges));
            check_code(i_code, 1'b0, "i_code in startup");
            check_code(q_code, 1'b0, "q_code in startup");
            check_code(count_valid, 1'b0, "count_valid in startup");
            check_count(edge_count, '0, 0, "edge_count in startup");
        end
    endtask

    // Leaves the bench just past edge N+1 where k is zero
    task automatic apply_profile(input profile_sel_t sel, input phase_t off);
        profile_sel  = sel;
        phase_offset = off;
        apply        = 1'b1;
        // Edge N latches the profile
        next_cycle;
        apply = 1'b0;
        // Edge N+1 restarts phase and window
        next_cycle;
    endtask

    // I/Q against the phase model and count_valid only at the window end
    task automatic check_trajectory(input tuning_t word, input phase_t off,
                                    input int cycles, input string tag);
        int k;
        for (k = 0; k < cycles; k++)
        begin
            if (k > 0)
            begin
                next_cycle;
            end
            check_code(i_code, model_code(word, off, k, '0),
                       $sformatf("%s i_code k=%0d", tag, k));
            check_code(q_code, model_code(word, off, k, QUARTER),
                       $sformatf("%s q_code k=%0d", tag, k));
            check_code(count_valid, k == GATE,
                       $sformatf("%s count_valid k=%0d", tag, k));
        end
    endtask

    // Second window is the first one free of the restart edge
    task automatic wait_second_valid(input edge_cnt_t expected, input int k_start,
                                     input string tag);
        int k;
        k = k_start;
        while (count_valid !== 1'b1)
        begin
            if (k > k_start + VALID_TIMEOUT)
            begin
                report_failure($sformatf("timeout: count_valid never arrived (%s)", tag));
            end
            next_cycle;
            k++;
            check_code(count_valid, k == 2 * GATE,
                       $sformatf("%s count_valid k=%0d", tag, k));
        end
        check_count(edge_count, expected, 1, $sformatf("%s edge_count", tag));
    endtask

    task automatic run_row(input stim_row_t row, input string tag);
        apply_profile(row.sel, row.offset);
        check_trajectory(row.word, row.offset, TRACE_CYCLES, tag);
        wait_second_valid(row.count, TRACE_CYCLES - 1, tag);
    endtask

    initial
    begin
        xtal_in      = 1'b0;
        rst          = 1'b1;
        apply        = 1'b0;
        profile_sel  = '0;
        phase_offset = '0;
        void'($urandom(SEED));

        // Expected counts are word / 256 for a 256-cycle window
        set_row(0, 2'd0, 1'b0, 16'h0000, 16'h3300, 9'd51);
        set_row(1, 2'd1, 1'b1, 16'h0000, 16'h1000, 9'd16);
        set_row(2, 2'd2, 1'b0, 16'h2a00, 16'h0800, 9'd8);
        set_row(3, 2'd3, 1'b1, 16'h0000, 16'h4000, 9'd64);

        // External reset for 3 cycles
        repeat (3)
        begin
            next_cycle;
            check_code(core_rst, 1'b1, "core_rst while rst high");
        end
        rst = 1'b0;

        // Apply during startup must be ignored
        profile_sel  = 2'd3;
        phase_offset = 16'h8000;
        apply        = 1'b1;
        wait_core_release();
        apply = 1'b0;

        // Nothing loaded yet, so outputs stay quiet
        repeat (4)
        begin
            next_cycle;
            check_code(i_code, 1'b0, "i_code before first apply");
            check_code(q_code, 1'b0, "q_code before first apply");
            check_code(count_valid, 1'b0, "count_valid before first apply");
            check_count(edge_count, '0, 0, "edge_count before first apply");
        end

        for (int row_idx = 0; row_idx < `OSC_PROFILE_COUNT; row_idx++)
        begin
            run_row(stim_table[row_idx], $sformatf("profile %0d", row_idx));
        end

        // Re-apply mid window where the old window end must not show up
        apply_profile(2'd2, 16'h1234);
        check_trajectory(16'h0800, 16'h1234, 120, "before re-apply");
        rnd_word    = $urandom;
        reapply_off = rnd_word[`OSC_PHASE_W-1:0];
        apply_profile(2'd0, reapply_off);
        check_trajectory(16'h3300, reapply_off, TRACE_CYCLES, "re-apply");
        wait_second_valid(9'd51, TRACE_CYCLES - 1, "re-apply");

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- project.f
+incdir+include
design/osc_clk_pkg.sv
design/nco_pkg.sv
design/tuning_if.sv
design/startup_reset.sv
design/tuning_select.sv
design/nco_core.sv
design/freq_meter.sv
design/osc_top.sv
verification/osc_top_tb.sv
